// ==== Bender.yml ====
package:
  name: thor_decode

sources:
  - hw/thor_decode_pkg.sv
  - hw/thor_decode_regs.sv
  - hw/thor_decode_imm.sv
  - hw/thor_decode_ctrl.sv
  - hw/thor_decoder.sv
  - hw/thor_decode_stage.sv
  - target: test
    files:
      - tests/thor_decode_tb.sv

// ==== hw/thor_decode_ctrl.sv ====
// Control decoder
// Derives the instruction class flags, memory access size, multi-cycle
// detection, branch target, link register target and the effective
// float rounding mode. Register numbers and immediate stay at zero
// here and are filled in by the other field decoders.

`timescale 1ns/1ps
`default_nettype none

module thor_decode_ctrl (
	input  thor_decode_pkg::instruction_t ir,
	input  logic [3:0]                    distk_depth,
	input  logic [2:0]                    dfrm,
	output thor_decode_pkg::deco_t        ctrl,
	output logic                          is_exi
);

	assign is_exi = ir.any.opcode == thor_decode_pkg::EXI;

	always_comb
	begin
		ctrl = '0;

		// ====================================================================
		// Memory operations
		// ====================================================================
		case (ir.any.opcode)
		thor_decode_pkg::LDB,
		thor_decode_pkg::LDBU,
		thor_decode_pkg::LDW,
		thor_decode_pkg::LDWU,
		thor_decode_pkg::LDO:
			ctrl.ld = 1'b1;
		thor_decode_pkg::STB,
		thor_decode_pkg::STW,
		thor_decode_pkg::STO:
			ctrl.st = 1'b1;
		default:
			;
		endcase

		// Zero-extending loads
		ctrl.ldz = ir.any.opcode == thor_decode_pkg::LDBU ||
			ir.any.opcode == thor_decode_pkg::LDWU;

		case (ir.any.opcode)
		thor_decode_pkg::LDB, thor_decode_pkg::LDBU, thor_decode_pkg::STB:
			ctrl.memsz = thor_decode_pkg::byt;
		thor_decode_pkg::LDW, thor_decode_pkg::LDWU, thor_decode_pkg::STW:
			ctrl.memsz = thor_decode_pkg::wyde;
		default:
			ctrl.memsz = thor_decode_pkg::octa;
		endcase

		// ====================================================================
		// Arithmetic and float
		// ====================================================================
		case (ir.any.opcode)
		thor_decode_pkg::R2:
		begin
			ctrl.mul = ir.r3.func == thor_decode_pkg::MUL;
			ctrl.div = ir.r3.func == thor_decode_pkg::DIV ||
				ir.r3.func == thor_decode_pkg::DIVU;
		end
		thor_decode_pkg::MULI:
			ctrl.mul = 1'b1;
		thor_decode_pkg::DIVI:
			ctrl.div = 1'b1;
		default:
			;
		endcase

		ctrl.multi_cycle = ctrl.mul | ctrl.div | ctrl.ld | ctrl.st;
		ctrl.is_float = ir.any.opcode == thor_decode_pkg::DF2;

		// rm of 7 selects the dynamic rounding mode
		if (ctrl.is_float && ir.r3.rm != 3'd7)
			ctrl.dfrm = ir.r3.rm;
		else
			ctrl.dfrm = dfrm;

		// ====================================================================
		// Flow control
		// ====================================================================
		ctrl.jmp = ir.any.opcode == thor_decode_pkg::JMP;
		ctrl.bra = ir.any.opcode == thor_decode_pkg::BRA;
		ctrl.rts = ir.any.opcode == thor_decode_pkg::RTS;
		case (ir.any.opcode)
		thor_decode_pkg::JEQ, thor_decode_pkg::JNE, thor_decode_pkg::JLT:
			ctrl.jxx = 1'b1;
		default:
			ctrl.jxx = 1'b0;
		endcase
		ctrl.flowchg = ctrl.jmp | ctrl.bra | ctrl.jxx | ctrl.rts;

		// Word displacements become byte offsets
		if (ctrl.jmp || ctrl.bra)
			ctrl.jmptgt = {{39{ir.jmp.disp[22]}}, ir.jmp.disp, 2'b00};
		else if (ctrl.jxx)
			ctrl.jmptgt = {{52{ir.jxx.disp[9]}}, ir.jxx.disp, 2'b00};
		else
			ctrl.jmptgt = '0;

		// Branches link through lk and everything else through the exception stack
		// lk sits in bits 8..7 in both branch formats
		if (ctrl.jmp || ctrl.bra || ctrl.jxx)
			ctrl.Ct = {2'b00, ir.jmp.lk};
		else
			ctrl.Ct = 4'h8 + distk_depth;

		// Register file write
		case (ir.any.opcode)
		thor_decode_pkg::R2,
		thor_decode_pkg::ADDI,
		thor_decode_pkg::MULI,
		thor_decode_pkg::DIVI,
		thor_decode_pkg::DF2:
			ctrl.rfwr = 1'b1;
		default:
			ctrl.rfwr = ctrl.ld;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/thor_decode_imm.sv ====
// Immediate decoder
// Sign-extends the 13-bit immediate of the register-immediate and
// memory formats. A pending EXI prefix supplies the upper 24 bits,
// and the resulting 37-bit constant is sign-extended to 64 bits.

`timescale 1ns/1ps
`default_nettype none

module thor_decode_imm (
	input  thor_decode_pkg::instruction_t ir,
	input  thor_decode_pkg::xstate_t      xstate,
	output logic [63:0]                   imm
);

	// Merge the prefix payload above the instruction immediate
	function automatic logic [63:0] ext_imm(
		input logic [12:0]              imm13,
		input thor_decode_pkg::xstate_t xs
	);
		if (xs.xval)
			ext_imm = {{27{xs.xpayload[23]}}, xs.xpayload, imm13};
		else
			ext_imm = {{51{imm13[12]}}, imm13};
	endfunction

	// The ri and mem views share the immediate bits
	always_comb
	begin
		case (ir.any.opcode)
		// Arithmetic with immediate
		thor_decode_pkg::ADDI,
		thor_decode_pkg::MULI,
		thor_decode_pkg::DIVI,
		// Address displacement of loads and stores
		thor_decode_pkg::LDB,
		thor_decode_pkg::LDBU,
		thor_decode_pkg::LDW,
		thor_decode_pkg::LDWU,
		thor_decode_pkg::LDO,
		thor_decode_pkg::STB,
		thor_decode_pkg::STW,
		thor_decode_pkg::STO:
			imm = ext_imm(ir.ri.imm, xstate);
		default:
			imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/thor_decode_pkg.sv ====
// Thor decode package
// Shared types for the decode stage: the instruction word with its
// format views, the reduced opcode and function maps, memory sizes,
// the decode record and the immediate prefix state.

`default_nettype none

package thor_decode_pkg;

	// Architectural register field width
	parameter int NREGS_LOG = 5;

	// ========================================================================
	// Opcode and function maps
	// ========================================================================

	typedef enum logic [6:0] {
		NOP  = 7'h00,
		R2   = 7'h02,
		ADDI = 7'h04,
		MULI = 7'h06,
		DIVI = 7'h07,
		DF2  = 7'h0A,
		JMP  = 7'h20,
		BRA  = 7'h21,
		JEQ  = 7'h26,
		JNE  = 7'h27,
		JLT  = 7'h28,
		RTS  = 7'h2C,
		BRK  = 7'h30,
		LDB  = 7'h40,
		LDBU = 7'h41,
		LDW  = 7'h42,
		LDWU = 7'h43,
		LDO  = 7'h46,
		STB  = 7'h50,
		STW  = 7'h51,
		STO  = 7'h53,
		EXI  = 7'h58
	} opcode_e;

	// Function field of R2 and DF2
	typedef enum logic [6:0] {
		ADD   = 7'h04,
		SUB   = 7'h05,
		MUL   = 7'h08,
		DIV   = 7'h10,
		DIVU  = 7'h11,
		DFADD = 7'h20,
		DFMUL = 7'h22
	} func_e;

	typedef enum logic [1:0] {
		byt   = 2'd0,
		wyde  = 2'd1,
		tetra = 2'd2,
		octa  = 2'd3
	} memsz_e;

	// ========================================================================
	// Instruction formats
	// ========================================================================

	typedef struct packed {
		logic [14:0]          body;
		logic [NREGS_LOG-1:0] Ra;
		logic [NREGS_LOG-1:0] Rt;
		opcode_e              opcode;
	} any_fmt_t;

	typedef struct packed {
		func_e                func;
		logic [2:0]           rm;
		logic [NREGS_LOG-1:0] Rb;
		logic [NREGS_LOG-1:0] Ra;
		logic [NREGS_LOG-1:0] Rt;
		opcode_e              opcode;
	} r3_fmt_t;

	// Register plus immediate, also used by loads and stores
	typedef struct packed {
		logic [1:0]           spare;
		logic [12:0]          imm;
		logic [NREGS_LOG-1:0] Ra;
		logic [NREGS_LOG-1:0] Rt;
		opcode_e              opcode;
	} ri_fmt_t;

	// Conditional branch, displacement counted in words
	typedef struct packed {
		logic [9:0]           disp;
		logic [NREGS_LOG-1:0] Rb;
		logic [NREGS_LOG-1:0] Ra;
		logic [2:0]           pad;
		logic [1:0]           lk;
		opcode_e              opcode;
	} jxx_fmt_t;

	typedef struct packed {
		logic [22:0] disp;
		logic [1:0]  lk;
		opcode_e     opcode;
	} jmp_fmt_t;

	typedef struct packed {
		logic [23:0] payload;
		logic        pad;
		opcode_e     opcode;
	} exi_fmt_t;

	typedef union packed {
		any_fmt_t any;
		r3_fmt_t  r3;
		ri_fmt_t  ri;
		ri_fmt_t  mem;
		jxx_fmt_t jxx;
		jmp_fmt_t jmp;
		exi_fmt_t exi;
	} instruction_t;

	// ========================================================================
	// Decode record and prefix state
	// ========================================================================

	typedef struct packed {
		logic [NREGS_LOG:0] Ra;
		logic [NREGS_LOG:0] Rb;
		logic [NREGS_LOG:0] Rt;
		logic               rfwr;
		logic [63:0]        imm;
		logic               ld;
		logic               ldz;
		logic               st;
		memsz_e             memsz;
		logic               mul;
		logic               div;
		logic               jmp;
		logic               bra;
		logic               jxx;
		logic               rts;
		logic               flowchg;
		logic [63:0]        jmptgt;
		logic [3:0]         Ct;
		logic               multi_cycle;
		logic [2:0]         dfrm;
		logic               is_float;
	} deco_t;

	typedef struct packed {
		logic        xval;
		logic [23:0] xpayload;
	} xstate_t;

endpackage

`default_nettype wire

// ==== hw/thor_decode_regs.sv ====
// Register field decoder
// Maps the Ra, Rb and Rt fields of an instruction to physical register
// numbers. Register 31 is the stack pointer and is banked by the
// current privilege level, giving physical registers 32 to 39.

`timescale 1ns/1ps
`default_nettype none

module thor_decode_regs (
	input  thor_decode_pkg::instruction_t            ir,
	input  logic [2:0]                               sp_sel,
	output logic [thor_decode_pkg::NREGS_LOG:0]      Ra,
	output logic [thor_decode_pkg::NREGS_LOG:0]      Rb,
	output logic [thor_decode_pkg::NREGS_LOG:0]      Rt
);

	// Field 31 selects the banked stack pointer
	function automatic logic [thor_decode_pkg::NREGS_LOG:0] map_reg(
		input logic [thor_decode_pkg::NREGS_LOG-1:0] fld,
		input logic [2:0]                            sel
	);
		if (fld == '1)
			map_reg = {1'b1, {(thor_decode_pkg::NREGS_LOG-3){1'b0}}, sel};
		else
			map_reg = {1'b0, fld};
	endfunction

	logic no_src;

	// Unconditional flow changes carry no source registers
	always_comb
	begin
		case (ir.any.opcode)
		thor_decode_pkg::JMP,
		thor_decode_pkg::BRA,
		thor_decode_pkg::RTS:
			no_src = 1'b1;
		default:
			no_src = 1'b0;
		endcase
	end

	always_comb
	begin
		if (no_src)
		begin
			Ra = '0;
			Rb = '0;
		end
		else
		begin
			Ra = map_reg(ir.any.Ra, sp_sel);
			Rb = map_reg(ir.r3.Rb, sp_sel);
		end
		// Stores read the data register through this field
		Rt = map_reg(ir.any.Rt, sp_sel);
	end

endmodule

`default_nettype wire

// ==== hw/thor_decode_stage.sv ====
// Thor decode stage
// Registers the decode record one cycle after an instruction is
// accepted. An EXI prefix is captured here and applied to the next
// accepted instruction. A stall holds the output and prefix state.

`timescale 1ns/1ps
`default_nettype none

module thor_decode_stage (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          ir_valid,
	input  thor_decode_pkg::instruction_t ir,
	input  logic                          stall,
	input  logic [2:0]                    sp_sel,
	input  logic [3:0]                    distk_depth,
	input  logic [2:0]                    dfrm,
	output thor_decode_pkg::deco_t        deco,
	output logic                          deco_valid
);

	thor_decode_pkg::deco_t   deco_d;
	thor_decode_pkg::xstate_t xstate;
	logic                     is_exi;
	logic                     accept;

	assign accept = ir_valid & ~stall;

	thor_decoder i_decoder (
		.ir          (ir),
		.xstate      (xstate),
		.sp_sel      (sp_sel),
		.distk_depth (distk_depth),
		.dfrm        (dfrm),
		.deco        (deco_d),
		.is_exi      (is_exi)
	);

	// ========================================================================
	// Output register
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			deco <= '0;
			deco_valid <= 1'b0;
		end
		else if (!stall)
		begin
			// A prefix on its own produces no record
			deco_valid <= ir_valid & ~is_exi;
			if (ir_valid && !is_exi)
				deco <= deco_d;
		end
	end

	// ========================================================================
	// Prefix state
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			xstate.xval <= 1'b0;
		else if (accept)
			xstate.xval <= is_exi;
	end

	always_ff @(posedge clk)
	begin
		if (accept && is_exi)
			xstate.xpayload <= ir.exi.payload;
	end

endmodule

`default_nettype wire

// ==== hw/thor_decoder.sv ====
// Combinational instruction decoder
// Runs the register, immediate and control field decoders in parallel
// on one instruction word and merges their results into a single
// decode record.

`timescale 1ns/1ps
`default_nettype none

module thor_decoder (
	input  thor_decode_pkg::instruction_t ir,
	input  thor_decode_pkg::xstate_t      xstate,
	input  logic [2:0]                    sp_sel,
	input  logic [3:0]                    distk_depth,
	input  logic [2:0]                    dfrm,
	output thor_decode_pkg::deco_t        deco,
	output logic                          is_exi
);

	logic [thor_decode_pkg::NREGS_LOG:0] ra;
	logic [thor_decode_pkg::NREGS_LOG:0] rb;
	logic [thor_decode_pkg::NREGS_LOG:0] rt;
	logic [63:0]                         imm;
	thor_decode_pkg::deco_t              ctrl;

	thor_decode_regs i_regs (
		.ir     (ir),
		.sp_sel (sp_sel),
		.Ra     (ra),
		.Rb     (rb),
		.Rt     (rt)
	);

	thor_decode_imm i_imm (
		.ir     (ir),
		.xstate (xstate),
		.imm    (imm)
	);

	thor_decode_ctrl i_ctrl (
		.ir          (ir),
		.distk_depth (distk_depth),
		.dfrm        (dfrm),
		.ctrl        (ctrl),
		.is_exi      (is_exi)
	);

	// Control fields come through, register numbers and immediate overlay
	always_comb
	begin
		deco = ctrl;
		deco.Ra = ra;
		deco.Rb = rb;
		deco.Rt = rt;
		deco.imm = imm;
	end

endmodule

`default_nettype wire

// ==== tests/thor_decode_tb.sv ====
// Thor decode stage testbench
// Applies a table of instruction words to the decode stage and checks
// the registered decode record one cycle later. Covers register
// mapping, immediates with EXI prefixes, memory and branch decode,
// rounding mode selection, stall and idle cycles.

`timescale 1ns/1ps
`default_nettype none

module thor_decode_tb;

	typedef struct packed {
		logic [31:0] ir;
		logic        ir_valid;
		logic        stall;
		logic [2:0]  sp_sel;
		logic [3:0]  distk_depth;
		logic [2:0]  dfrm;
	} stim_t;

	typedef struct packed {
		logic [5:0]  Ra;
		logic [5:0]  Rb;
		logic [5:0]  Rt;
		logic        rfwr;
		logic [63:0] imm;
		logic [1:0]  memsz;
		logic        ld;
		logic        ldz;
		logic        st;
		logic        mul;
		logic        div;
		logic        multi_cycle;
		logic [3:0]  flow;
		logic        flowchg;
		logic [63:0] jmptgt;
		logic [3:0]  Ct;
		logic [2:0]  dfrm;
		logic        is_float;
	} expect_t;

	logic                          clk;
	logic                          rst_n;
	logic                          ir_valid;
	thor_decode_pkg::instruction_t ir;
	logic                          stall;
	logic [2:0]                    sp_sel;
	logic [3:0]                    distk_depth;
	logic [2:0]                    dfrm;
	thor_decode_pkg::deco_t        deco;
	logic                          deco_valid;

	// Vector table with one slot per entry
	string   names[$];
	stim_t   stims[$];
	expect_t exps[$];
	logic    exp_valid[$];
	logic    hold[$];

	integer seed;
	int     errors;
	int     cycles;
	int     timeout_limit;

	thor_decode_stage i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.ir_valid    (ir_valid),
		.ir          (ir),
		.stall       (stall),
		.sp_sel      (sp_sel),
		.distk_depth (distk_depth),
		.dfrm        (dfrm),
		.deco        (deco),
		.deco_valid  (deco_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", timeout_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	// ========================================================================
	// Instruction encoders with spare bits filled at random
	// ========================================================================
	function automatic logic [31:0] enc_ri(thor_decode_pkg::opcode_e op, logic [4:0] rt,
		logic [4:0] ra, logic [12:0] imm13);
		thor_decode_pkg::instruction_t w;
		w.ri.opcode = op;
		w.ri.Rt = rt;
		w.ri.Ra = ra;
		w.ri.imm = imm13;
		w.ri.spare = 2'($random(seed));
		return w;
	endfunction

	function automatic logic [31:0] enc_r3(thor_decode_pkg::opcode_e op, logic [4:0] rt,
		logic [4:0] ra, logic [4:0] rb, logic [2:0] rm, thor_decode_pkg::func_e fn);
		thor_decode_pkg::instruction_t w;
		w.r3.opcode = op;
		w.r3.Rt = rt;
		w.r3.Ra = ra;
		w.r3.Rb = rb;
		w.r3.rm = rm;
		w.r3.func = fn;
		return w;
	endfunction

	function automatic logic [31:0] enc_jmp(thor_decode_pkg::opcode_e op, logic [1:0] lk,
		logic [22:0] disp);
		thor_decode_pkg::instruction_t w;
		w.jmp.opcode = op;
		w.jmp.lk = lk;
		w.jmp.disp = disp;
		return w;
	endfunction

	// Pad bits overlap the Rt field and stay zero
	function automatic logic [31:0] enc_jxx(thor_decode_pkg::opcode_e op, logic [1:0] lk,
		logic [4:0] ra, logic [4:0] rb, logic [9:0] disp);
		thor_decode_pkg::instruction_t w;
		w.jxx.opcode = op;
		w.jxx.lk = lk;
		w.jxx.pad = 3'd0;
		w.jxx.Ra = ra;
		w.jxx.Rb = rb;
		w.jxx.disp = disp;
		return w;
	endfunction

	function automatic logic [31:0] enc_exi(logic [23:0] payload);
		thor_decode_pkg::instruction_t w;
		w.exi.opcode = thor_decode_pkg::EXI;
		w.exi.pad = 1'($random(seed));
		w.exi.payload = payload;
		return w;
	endfunction

	// ========================================================================
	// Table helpers
	// ========================================================================
	function automatic stim_t mk_stim(logic [31:0] w, logic v, logic s, logic [2:0] sp,
		logic [3:0] dd, logic [2:0] rm);
		stim_t st;
		st.ir = w;
		st.ir_valid = v;
		st.stall = s;
		st.sp_sel = sp;
		st.distk_depth = dd;
		st.dfrm = rm;
		return st;
	endfunction

	// Register-writing record of size octa with no target
	function automatic expect_t plain_exp(logic [5:0] ra, logic [5:0] rb, logic [5:0] rt,
		logic [63:0] imm, logic [3:0] ct, logic [2:0] rm);
		expect_t e;
		e = '0;
		e.Ra = ra;
		e.Rb = rb;
		e.Rt = rt;
		e.rfwr = 1'b1;
		e.imm = imm;
		e.memsz = 2'd3;
		e.Ct = ct;
		e.dfrm = rm;
		return e;
	endfunction

	// Only loads write the register file
	function automatic expect_t mem_exp(logic [5:0] ra, logic [5:0] rb, logic [5:0] rt,
		logic [63:0] imm, logic [1:0] sz, logic ld, logic ldz, logic st);
		expect_t e;
		e = plain_exp(ra, rb, rt, imm, 4'd10, 3'd5);
		e.rfwr = ld;
		e.memsz = sz;
		e.ld = ld;
		e.ldz = ldz;
		e.st = st;
		e.multi_cycle = 1'b1;
		return e;
	endfunction

	// Flow flags in the order jmp, bra, jxx, rts
	function automatic expect_t flow_exp(logic [5:0] ra, logic [5:0] rb, logic [5:0] rt,
		logic [63:0] tgt, logic [3:0] ct, logic [3:0] flow);
		expect_t e;
		e = plain_exp(ra, rb, rt, 64'd0, ct, 3'd5);
		e.rfwr = 1'b0;
		e.flow = flow;
		e.jmptgt = tgt;
		e.flowchg = 1'b1;
		return e;
	endfunction

	task automatic add_vec(string name, stim_t s, expect_t e, logic v, logic h);
		names.push_back(name);
		stims.push_back(s);
		exps.push_back(e);
		exp_valid.push_back(v);
		hold.push_back(h);
	endtask

	// Rb of register-immediate words comes from the low five immediate bits
	task automatic fill_table();
		expect_t e;
		// Register mapping and immediates
		e = plain_exp(6'd4, 6'd3, 6'd3, 64'h123, 4'd10, 3'd5);
		add_vec("addi_pos", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd3, 5'd4, 13'h0123),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd34, 6'd27, 6'd34, 64'hFFFF_FFFF_FFFF_FFFB, 4'd10, 3'd5);
		add_vec("addi_neg_sp2", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd31, 5'd31, 13'h1FFB),
			1, 0, 3'd2, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd12, 6'd8, 6'd39, 64'h8, 2'd3, 1, 0, 0);
		add_vec("ldo_sp7", mk_stim(enc_ri(thor_decode_pkg::LDO, 5'd31, 5'd12, 13'h0008),
			1, 0, 3'd7, 4'd2, 3'd5), e, 1, 0);
		// EXI prefix handling
		add_vec("exi_pos", mk_stim(enc_exi(24'h00ABCD), 1, 0, 3'd0, 4'd2, 3'd5), '0, 0, 1);
		e = plain_exp(6'd2, 6'd22, 6'd1, {27'd0, 24'h00ABCD, 13'h0456}, 4'd10, 3'd5);
		add_vec("addi_exi", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd1, 5'd2, 13'h0456),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd2, 6'd16, 6'd1, 64'h10, 4'd10, 3'd5);
		add_vec("addi_after_exi", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd1, 5'd2, 13'h0010),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		add_vec("exi_neg", mk_stim(enc_exi(24'hFFFFFE), 1, 0, 3'd0, 4'd2, 3'd5), '0, 0, 1);
		add_vec("gap_idle", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd0, 5'd0, 13'h0),
			0, 0, 3'd0, 4'd2, 3'd5), '0, 0, 1);
		e = plain_exp(6'd6, 6'd1, 6'd5, {{27{1'b1}}, 24'hFFFFFE, 13'h0001}, 4'd10, 3'd5);
		add_vec("addi_exi_neg", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd5, 5'd6, 13'h0001),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		// Loads, stores and multi-cycle arithmetic
		e = mem_exp(6'd6, 6'd32, 6'd5, 64'hFFFF_FFFF_FFFF_FFFF, 2'd0, 1, 0, 0);
		add_vec("ldb", mk_stim(enc_ri(thor_decode_pkg::LDB, 5'd5, 5'd6, 13'h1FFF),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd9, 6'd4, 6'd8, 64'h4, 2'd0, 1, 1, 0);
		add_vec("ldbu", mk_stim(enc_ri(thor_decode_pkg::LDBU, 5'd8, 5'd9, 13'h0004),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd11, 6'd0, 6'd10, 64'hFFFF_FFFF_FFFF_F000, 2'd1, 1, 0, 0);
		add_vec("ldw", mk_stim(enc_ri(thor_decode_pkg::LDW, 5'd10, 5'd11, 13'h1000),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd13, 6'd0, 6'd12, 64'h20, 2'd1, 1, 1, 0);
		add_vec("ldwu", mk_stim(enc_ri(thor_decode_pkg::LDWU, 5'd12, 5'd13, 13'h0020),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd15, 6'd2, 6'd14, 64'h2, 2'd0, 0, 0, 1);
		add_vec("stb", mk_stim(enc_ri(thor_decode_pkg::STB, 5'd14, 5'd15, 13'h0002),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd16, 6'd16, 6'd35, 64'hFFFF_FFFF_FFFF_FFF0, 2'd1, 0, 0, 1);
		add_vec("stw_sp3", mk_stim(enc_ri(thor_decode_pkg::STW, 5'd31, 5'd16, 13'h1FF0),
			1, 0, 3'd3, 4'd2, 3'd5), e, 1, 0);
		e = mem_exp(6'd18, 6'd0, 6'd17, 64'h40, 2'd3, 0, 0, 1);
		add_vec("sto", mk_stim(enc_ri(thor_decode_pkg::STO, 5'd17, 5'd18, 13'h0040),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd20, 6'd3, 6'd19, 64'h3, 4'd10, 3'd5);
		e.mul = 1'b1;
		e.multi_cycle = 1'b1;
		add_vec("muli", mk_stim(enc_ri(thor_decode_pkg::MULI, 5'd19, 5'd20, 13'h0003),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd22, 6'd30, 6'd21, 64'hFFFF_FFFF_FFFF_FFFE, 4'd10, 3'd5);
		e.div = 1'b1;
		e.multi_cycle = 1'b1;
		add_vec("divi", mk_stim(enc_ri(thor_decode_pkg::DIVI, 5'd21, 5'd22, 13'h1FFE),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd8, 6'd33, 6'd7, 64'd0, 4'd10, 3'd5);
		e.div = 1'b1;
		e.multi_cycle = 1'b1;
		add_vec("r2_divu_sp1", mk_stim(enc_r3(thor_decode_pkg::R2, 5'd7, 5'd8, 5'd31, 3'd0,
			thor_decode_pkg::DIVU), 1, 0, 3'd1, 4'd2, 3'd5), e, 1, 0);
		// Branches take Rt from the bits under the Rt field
		e = flow_exp(6'd0, 6'd0, 6'd17, 64'hFFFF_FFFF_FFFF_FFF0, 4'd1, 4'b1000);
		add_vec("jmp_neg", mk_stim(enc_jmp(thor_decode_pkg::JMP, 2'd1, 23'h7FFFFC),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = flow_exp(6'd0, 6'd0, 6'd30, 64'hFFFF_FFFF_FFFF_FFFC, 4'd2, 4'b0100);
		add_vec("bra_neg", mk_stim(enc_jmp(thor_decode_pkg::BRA, 2'd2, 23'h7FFFFF),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = flow_exp(6'd9, 6'd10, 6'd3, 64'hFFFF_FFFF_FFFF_FFF8, 4'd3, 4'b0010);
		add_vec("jeq_neg", mk_stim(enc_jxx(thor_decode_pkg::JEQ, 2'd3, 5'd9, 5'd10, 10'h3FE),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = flow_exp(6'd36, 6'd1, 6'd0, 64'hFFFF_FFFF_FFFF_F800, 4'd0, 4'b0010);
		add_vec("jlt_sp4", mk_stim(enc_jxx(thor_decode_pkg::JLT, 2'd0, 5'd31, 5'd1, 10'h200),
			1, 0, 3'd4, 4'd2, 3'd5), e, 1, 0);
		e = flow_exp(6'd0, 6'd0, 6'd0, 64'd0, 4'd10, 4'b0001);
		add_vec("rts", mk_stim(enc_ri(thor_decode_pkg::RTS, 5'd0, 5'd0, 13'h0),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd0, 6'd0, 6'd0, 64'd0, 4'd13, 3'd5);
		e.rfwr = 1'b0;
		add_vec("brk", mk_stim(enc_ri(thor_decode_pkg::BRK, 5'd0, 5'd0, 13'h0),
			1, 0, 3'd0, 4'd5, 3'd5), e, 1, 0);
		// Rounding mode
		e = plain_exp(6'd3, 6'd4, 6'd2, 64'd0, 4'd10, 3'd3);
		e.is_float = 1'b1;
		add_vec("df2_rm3", mk_stim(enc_r3(thor_decode_pkg::DF2, 5'd2, 5'd3, 5'd4, 3'd3,
			thor_decode_pkg::DFADD), 1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
		e = plain_exp(6'd3, 6'd4, 6'd2, 64'd0, 4'd10, 3'd6);
		e.is_float = 1'b1;
		add_vec("df2_rm7", mk_stim(enc_r3(thor_decode_pkg::DF2, 5'd2, 5'd3, 5'd4, 3'd7,
			thor_decode_pkg::DFMUL), 1, 0, 3'd0, 4'd2, 3'd6), e, 1, 0);
		// Stall and idle cycles hold the last record
		add_vec("stall_valid", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd1, 5'd1, 13'h0777),
			1, 1, 3'd0, 4'd2, 3'd5), '0, 1, 1);
		add_vec("stall_idle", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd1, 5'd1, 13'h0777),
			0, 1, 3'd0, 4'd2, 3'd5), '0, 1, 1);
		add_vec("idle", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd1, 5'd1, 13'h0777),
			0, 0, 3'd0, 4'd2, 3'd5), '0, 0, 1);
		e = plain_exp(6'd26, 6'd28, 6'd25, 64'hABC, 4'd10, 3'd5);
		add_vec("addi_last", mk_stim(enc_ri(thor_decode_pkg::ADDI, 5'd25, 5'd26, 13'h0ABC),
			1, 0, 3'd0, 4'd2, 3'd5), e, 1, 0);
	endtask

	// ========================================================================
	// Drive and compare
	// ========================================================================
	task automatic apply(stim_t s);
		ir <= s.ir;
		ir_valid <= s.ir_valid;
		stall <= s.stall;
		sp_sel <= s.sp_sel;
		distk_depth <= s.distk_depth;
		dfrm <= s.dfrm;
	endtask

	task automatic report_mismatch(string name, string field, logic [63:0] exp_v,
		logic [63:0] act_v);
		errors++;
		$display("** Error %s %s: expected %h, actual %h", name, field, exp_v, act_v);
	endtask

	task automatic compare_record(string name, logic v, expect_t e);
		if (deco_valid !== v)
			report_mismatch(name, "deco_valid", 64'(v), 64'(deco_valid));
		if (deco.Ra !== e.Ra)
			report_mismatch(name, "Ra", 64'(e.Ra), 64'(deco.Ra));
		if (deco.Rb !== e.Rb)
			report_mismatch(name, "Rb", 64'(e.Rb), 64'(deco.Rb));
		if (deco.Rt !== e.Rt)
			report_mismatch(name, "Rt", 64'(e.Rt), 64'(deco.Rt));
		if (deco.rfwr !== e.rfwr)
			report_mismatch(name, "rfwr", 64'(e.rfwr), 64'(deco.rfwr));
		if (deco.imm !== e.imm)
			report_mismatch(name, "imm", e.imm, deco.imm);
		if (deco.memsz !== e.memsz)
			report_mismatch(name, "memsz", 64'(e.memsz), 64'(deco.memsz));
		if (deco.ld !== e.ld || deco.ldz !== e.ldz || deco.st !== e.st)
			report_mismatch(name, "ld/ldz/st", 64'({e.ld, e.ldz, e.st}),
				64'({deco.ld, deco.ldz, deco.st}));
		if (deco.mul !== e.mul || deco.div !== e.div)
			report_mismatch(name, "mul/div", 64'({e.mul, e.div}), 64'({deco.mul, deco.div}));
		if (deco.multi_cycle !== e.multi_cycle)
			report_mismatch(name, "multi_cycle", 64'(e.multi_cycle), 64'(deco.multi_cycle));
		if ({deco.jmp, deco.bra, deco.jxx, deco.rts} !== e.flow)
			report_mismatch(name, "jmp/bra/jxx/rts", 64'(e.flow),
				64'({deco.jmp, deco.bra, deco.jxx, deco.rts}));
		if (deco.flowchg !== e.flowchg)
			report_mismatch(name, "flowchg", 64'(e.flowchg), 64'(deco.flowchg));
		if (deco.jmptgt !== e.jmptgt)
			report_mismatch(name, "jmptgt", e.jmptgt, deco.jmptgt);
		if (deco.Ct !== e.Ct)
			report_mismatch(name, "Ct", 64'(e.Ct), 64'(deco.Ct));
		if (deco.dfrm !== e.dfrm)
			report_mismatch(name, "dfrm", 64'(e.dfrm), 64'(deco.dfrm));
		if (deco.is_float !== e.is_float)
			report_mismatch(name, "is_float", 64'(e.is_float), 64'(deco.is_float));
	endtask

	initial
	begin
		expect_t last;
		seed = 68;
		errors = 0;
		cycles = 0;
		rst_n = 1'b0;
		ir_valid = 1'b0;
		ir = '0;
		stall = 1'b0;
		sp_sel = 3'd0;
		distk_depth = 4'd0;
		dfrm = 3'd0;
		last = '0;
		fill_table();
		timeout_limit = 10 + 3 * names.size() + 20;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_record("after_reset", 1'b0, last);

		// Entry i is driven on one edge and checked after the next
		for (int i = 0; i <= names.size(); i++)
		begin
			@(posedge clk);
			if (i < names.size())
				apply(stims[i]);
			else
				apply(mk_stim(32'd0, 0, 0, 3'd0, 4'd0, 3'd0));
			@(negedge clk);
			if (i > 0)
			begin
				if (hold[i-1])
					compare_record(names[i-1], exp_valid[i-1], last);
				else
				begin
					compare_record(names[i-1], exp_valid[i-1], exps[i-1]);
					last = exps[i-1];
				end
			end
		end

		$display("Checked %0d records, %0d errors", names.size() + 1, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/thor_decode_pkg.sv
hw/thor_decode_regs.sv
hw/thor_decode_imm.sv
hw/thor_decode_ctrl.sv
hw/thor_decoder.sv
hw/thor_decode_stage.sv
tests/thor_decode_tb.sv
